// File: build.f
common/obi_pkg.sv
common/axi_lite_pkg.sv
src/obi_instr_bridge.sv
src/obi_data_bridge.sv
src/axi_lite_arbiter.sv
src/obi_axi_subsys_top.sv
verif/tb_clkgen.sv
verif/tb_obi_axi_top.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; the exit status is the simulation result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 \
  --top-module tb_obi_axi_top -f build.f -o tb_obi_axi_top
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_obi_axi_top
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation run ended with status $status"
  exit "$status"
fi

exit 0

// File: verif/tb_obi_axi_top.sv
// Slave model serves one master transaction at a time and paired table entries must use distinct words
`timescale 1ns/1ps

module tb_obi_axi_top;

  localparam int NUM_OPS     = 17;
  localparam int CYCLE_LIMIT = 20 * NUM_OPS + 100;
  localparam logic P_I       = 1'b0;
  localparam logic P_D       = 1'b1;
  localparam logic [1:0] RESP_OK  = 2'b00;
  localparam logic [1:0] RESP_ERR = 2'b10;

  typedef struct packed {
    logic        pair;      // Issued in the same cycle as the next entry
    logic        port;      // 0 instruction, 1 data
    logic        we;
    logic [31:0] addr;
    logic [3:0]  be;
    logic [31:0] wdata;
    logic [31:0] exp_data;
    logic        exp_err;
  } op_t;

  logic        clk, arst_n;
  logic        instr_req, instr_gnt, instr_rvalid, instr_err;
  logic [31:0] instr_addr, instr_rdata;
  logic        data_req, data_we, data_gnt, data_rvalid, data_err;
  logic [3:0]  data_be;
  logic [31:0] data_addr, data_wdata, data_rdata;
  logic        m_awvalid, m_awready, m_wvalid, m_wready, m_bvalid, m_bready;
  logic        m_arvalid, m_arready, m_rvalid, m_rready;
  logic [31:0] m_awaddr, m_wdata, m_araddr, m_rdata;
  logic [3:0]  m_wstrb;
  logic [1:0]  m_bresp, m_rresp;

  op_t         ops [NUM_OPS];
  logic [31:0] slave_mem [256];
  logic [31:0] ref_mem [256];
  logic [31:0] bus_addr_q [$];
  logic [31:0] lfsr_q;
  int          pulses [2];
  int          accepts [2];
  int          cycle_cnt;

  tb_clkgen #(.PERIOD(40), .RST_CYCLES(3)) u_clkgen (.clk_o(clk), .arst_n_o(arst_n));

  obi_axi_subsys_top #(.ADDR_W(32), .DATA_W(32)) uut (
    .clk_i (clk), .arst_n_i (arst_n),
    .instr_req_i (instr_req), .instr_addr_i (instr_addr), .instr_gnt_o (instr_gnt),
    .instr_rvalid_o (instr_rvalid), .instr_rdata_o (instr_rdata), .instr_err_o (instr_err),
    .data_req_i (data_req), .data_we_i (data_we), .data_be_i (data_be),
    .data_addr_i (data_addr), .data_wdata_i (data_wdata), .data_gnt_o (data_gnt),
    .data_rvalid_o (data_rvalid), .data_rdata_o (data_rdata), .data_err_o (data_err),
    .m_awvalid_o (m_awvalid), .m_awready_i (m_awready), .m_awaddr_o (m_awaddr),
    .m_wvalid_o (m_wvalid), .m_wready_i (m_wready), .m_wdata_o (m_wdata),
    .m_wstrb_o (m_wstrb), .m_bvalid_i (m_bvalid), .m_bready_o (m_bready),
    .m_bresp_i (m_bresp), .m_arvalid_o (m_arvalid), .m_arready_i (m_arready),
    .m_araddr_o (m_araddr), .m_rvalid_i (m_rvalid), .m_rready_o (m_rready),
    .m_rdata_i (m_rdata), .m_rresp_i (m_rresp)
  );

  // ----------------------------------------
  // Failure reporting
  // ----------------------------------------

  task automatic value_mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("[ERROR] time %0t: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
    $display("Simulation FAILED");
    $fatal(1, "value mismatch");
  endtask

  task automatic protocol_error(input string what);
    $display("Error at time %0t: %s", $time, what);
    $display("Simulation FAILED");
    $fatal(1, "protocol error");
  endtask

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic lfsr_next_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  // 0 to 3 cycles from two LFSR bits
  function automatic int unsigned ready_delay();
    logic [1:0] d;
    d[1] = lfsr_next_bit();
    d[0] = lfsr_next_bit();
    return 32'(d);
  endfunction

  // Initial contents depend on every bit of the byte address
  function automatic logic [31:0] fill_word(input int unsigned idx);
    logic [31:0] a;
    a = idx << 2;
    return (a * 32'h9e37_79b9) ^ {a[15:0], ~a[15:0]};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  function automatic logic port_gnt(input logic port);
    return port ? data_gnt : instr_gnt;
  endfunction

  task automatic drive_port(input op_t op, input logic req);
    if (op.port == P_I) begin
      instr_req  = req;
      instr_addr = op.addr;
    end else begin
      data_req   = req;
      data_we    = op.we;
      data_be    = op.be;
      data_addr  = op.addr;
      data_wdata = op.wdata;
    end
  endtask

  // ----------------------------------------
  // Stimulus table
  // ----------------------------------------

  task automatic set_op(input int i, input logic pair, input logic port, input logic we,
                        input logic [31:0] addr, input logic [3:0] be, input logic [31:0] wdata);
    ops[i].pair  = pair;
    ops[i].port  = port;
    ops[i].we    = we;
    ops[i].addr  = addr;
    ops[i].be    = be;
    ops[i].wdata = wdata;
  endtask

  task automatic build_table();
    // Same-cycle pair right after reset, instruction first
    set_op(0,  1'b1, P_I, 1'b0, 32'h0000_0000, 4'h0, 32'h0);
    set_op(1,  1'b0, P_D, 1'b0, 32'h0000_0100, 4'h0, 32'h0);
    set_op(2,  1'b0, P_I, 1'b0, 32'h0000_0004, 4'h0, 32'h0);
    // Partial write then read back
    set_op(3,  1'b0, P_D, 1'b1, 32'h0000_0020, 4'b0101, 32'hdead_beef);
    set_op(4,  1'b0, P_D, 1'b0, 32'h0000_0020, 4'h0, 32'h0);
    set_op(5,  1'b1, P_D, 1'b1, 32'h0000_0024, 4'b1100, 32'h1234_5678);
    set_op(6,  1'b0, P_I, 1'b0, 32'h0000_0008, 4'h0, 32'h0);
    set_op(7,  1'b0, P_I, 1'b0, 32'h0000_0010, 4'h0, 32'h0);
    // Data port wins these pairs
    set_op(8,  1'b1, P_D, 1'b0, 32'h0000_0024, 4'h0, 32'h0);
    set_op(9,  1'b0, P_I, 1'b0, 32'h0000_0014, 4'h0, 32'h0);
    set_op(10, 1'b1, P_D, 1'b1, 32'h0000_0028, 4'b1111, 32'hcafe_f00d);
    set_op(11, 1'b0, P_I, 1'b0, 32'h0000_03fc, 4'h0, 32'h0);
    // Out-of-range write that would alias word 4 if truncated
    set_op(12, 1'b0, P_D, 1'b1, 32'h0000_0410, 4'b1111, 32'h5555_aaaa);
    set_op(13, 1'b0, P_D, 1'b0, 32'h0000_0010, 4'h0, 32'h0);
    set_op(14, 1'b0, P_I, 1'b0, 32'h0000_0800, 4'h0, 32'h0);
    set_op(15, 1'b0, P_D, 1'b0, 32'h0000_0400, 4'h0, 32'h0);
    set_op(16, 1'b0, P_D, 1'b0, 32'h0000_0028, 4'h0, 32'h0);
  endtask

  // Expected values from the reference copy, in table order
  task automatic fill_expected();
    logic [7:0] w;
    for (int i = 0; i < NUM_OPS; i++) begin
      w = ops[i].addr[9:2];
      ops[i].exp_err  = (ops[i].addr[31:10] != '0);
      ops[i].exp_data = (ops[i].we || ops[i].exp_err) ? 32'h0 : ref_mem[w];
      if (ops[i].we && !ops[i].exp_err) begin
        ref_mem[w] = merge_bytes(ref_mem[w], ops[i].wdata, ops[i].be);
      end
    end
  endtask

  // ----------------------------------------
  // OBI driver and checks
  // ----------------------------------------

  task automatic run_op(input int idx);
    op_t         op;
    logic        granted;
    logic        done;
    logic [31:0] got_data;
    logic        got_err;
    string       pfx;
    op   = ops[idx];
    done = 1'b0;
    pfx  = op.port ? "data_" : "instr_";
    @(negedge clk);
    drive_port(op, 1'b1);
    #1;
    // Previous response on this port was a single pulse
    assert (pulses[op.port] == accepts[op.port])
      else protocol_error({pfx, "rvalid_o pulse count differs from accepted requests"});
    granted = port_gnt(op.port);
    while (!granted) begin
      @(negedge clk);
      #1;
      granted = port_gnt(op.port);
    end
    accepts[op.port]++;
    @(negedge clk);
    // Request held high while busy, core must stall
    while (!done) begin
      if (op.port ? data_rvalid : instr_rvalid) begin
        got_data = op.port ? data_rdata : instr_rdata;
        got_err  = op.port ? data_err : instr_err;
        drive_port(op, 1'b0);
        done = 1'b1;
      end else begin
        #1;
        assert (!port_gnt(op.port)) else value_mismatch({pfx, "gnt_o"}, 32'd0, 32'd1);
        @(negedge clk);
      end
    end
    assert (got_data == op.exp_data) else value_mismatch({pfx, "rdata_o"}, op.exp_data, got_data);
    assert (got_err == op.exp_err)
      else value_mismatch({pfx, "err_o"}, 32'(op.exp_err), 32'(got_err));
  endtask

  // Master bus order against the round-robin rule
  task automatic check_bus_order(input int idx);
    logic [31:0] addr;
    assert (bus_addr_q.size() != 0) else protocol_error("no master transaction for a request");
    addr = bus_addr_q.pop_front();
    assert (addr == ops[idx].addr)
      else value_mismatch(ops[idx].we ? "m_awaddr_o" : "m_araddr_o", ops[idx].addr, addr);
  endtask

  // ----------------------------------------
  // AXI4-Lite slave model
  // ----------------------------------------

  task automatic serve_read();
    logic [31:0] addr;
    repeat (ready_delay()) @(negedge clk);
    // AR valid held until the slave takes it
    assert (m_arvalid) else value_mismatch("m_arvalid_o", 32'd1, 32'd0);
    m_arready = 1'b1;
    addr      = m_araddr;
    bus_addr_q.push_back(addr);
    @(negedge clk);
    m_arready = 1'b0;
    assert (!m_arvalid) else value_mismatch("m_arvalid_o", 32'd0, 32'd1);
    repeat (ready_delay()) @(negedge clk);
    m_rvalid = 1'b1;
    m_rdata  = (addr[31:10] == '0) ? slave_mem[addr[9:2]] : 32'h0;
    m_rresp  = (addr[31:10] == '0) ? RESP_OK : RESP_ERR;
    while (!m_rready) @(negedge clk);
    @(negedge clk);
    m_rvalid = 1'b0;
    m_rdata  = '0;
    m_rresp  = RESP_OK;
  endtask

  task automatic serve_write();
    int unsigned aw_wait, w_wait, n;
    logic        aw_taken, w_taken;
    logic [31:0] addr, wdata;
    logic [3:0]  strb;
    aw_wait  = ready_delay();
    w_wait   = ready_delay();
    aw_taken = 1'b0;
    w_taken  = 1'b0;
    n        = 0;
    // AW and W accepted on independent delays
    while (!(aw_taken && w_taken)) begin
      // Each valid stays up until its own handshake and drops after it
      assert (m_awvalid == !aw_taken)
        else value_mismatch("m_awvalid_o", 32'(!aw_taken), 32'(m_awvalid));
      assert (m_wvalid == !w_taken)
        else value_mismatch("m_wvalid_o", 32'(!w_taken), 32'(m_wvalid));
      m_awready = !aw_taken && (n >= aw_wait);
      m_wready  = !w_taken && (n >= w_wait);
      if (m_awready) begin
        addr     = m_awaddr;
        aw_taken = 1'b1;
        bus_addr_q.push_back(addr);
      end
      if (m_wready) begin
        wdata   = m_wdata;
        strb    = m_wstrb;
        w_taken = 1'b1;
      end
      n++;
      @(negedge clk);
    end
    m_awready = 1'b0;
    m_wready  = 1'b0;
    if (addr[31:10] == '0) slave_mem[addr[9:2]] = merge_bytes(slave_mem[addr[9:2]], wdata, strb);
    repeat (ready_delay()) @(negedge clk);
    m_bvalid = 1'b1;
    m_bresp  = (addr[31:10] == '0) ? RESP_OK : RESP_ERR;
    while (!m_bready) @(negedge clk);
    @(negedge clk);
    m_bvalid = 1'b0;
    m_bresp  = RESP_OK;
  endtask

  initial begin
    forever begin
      @(negedge clk);
      if (m_arvalid) serve_read();
      else if (m_awvalid) serve_write();
    end
  end

  // Count rvalid pulses per port at the falling edge
  initial begin
    forever begin
      @(negedge clk);
      if (instr_rvalid) pulses[P_I]++;
      if (data_rvalid) pulses[P_D]++;
    end
  end

  // Run limit
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Simulation FAILED");
    $fatal(1, "timeout");
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    int   i;
    int   first;
    int   second;
    logic last_port;
    logic [6:0] idle_bits;
    instr_req  = 1'b0;
    instr_addr = '0;
    data_req   = 1'b0;
    data_we    = 1'b0;
    data_be    = '0;
    data_addr  = '0;
    data_wdata = '0;
    m_awready  = 1'b0;
    m_wready   = 1'b0;
    m_bvalid   = 1'b0;
    m_bresp    = RESP_OK;
    m_arready  = 1'b0;
    m_rvalid   = 1'b0;
    m_rdata    = '0;
    m_rresp    = RESP_OK;
    lfsr_q     = 32'ha2d40963;
    pulses[P_I]  = 0;
    pulses[P_D]  = 0;
    accepts[P_I] = 0;
    accepts[P_D] = 0;
    for (int k = 0; k < 256; k++) begin
      slave_mem[k] = fill_word(k);
      ref_mem[k]   = fill_word(k);
    end
    build_table();
    fill_expected();
    // Quiet outputs through reset and before the first request
    repeat (5) begin
      @(negedge clk);
      #1;
      idle_bits = {instr_rvalid, data_rvalid, m_awvalid, m_wvalid, m_arvalid, m_bready, m_rready};
      assert (idle_bits == '0)
        else value_mismatch("{rvalid_o, m_*valid_o, m_*ready_o}", 32'd0, 32'(idle_bits));
    end
    // Instruction port has priority after reset
    last_port = P_D;
    i = 0;
    while (i < NUM_OPS) begin
      if (ops[i].pair) begin
        fork
          run_op(i);
          run_op(i + 1);
        join
        first  = (ops[i].port != last_port) ? i : i + 1;
        second = (first == i) ? i + 1 : i;
        check_bus_order(first);
        check_bus_order(second);
        last_port = ops[second].port;
        i += 2;
      end else begin
        run_op(i);
        check_bus_order(i);
        last_port = ops[i].port;
        i++;
      end
    end
    @(negedge clk);
    #1;
    if (pulses[P_I] == accepts[P_I] && pulses[P_D] == accepts[P_D] && bus_addr_q.size() == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      protocol_error("extra rvalid_o pulse or master transaction after the last request");
    end
  end

endmodule

// File: verif/tb_clkgen.sv
// Clock runs from time zero and reset is released on a falling edge after RST_CYCLES rising edges
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD     = 40,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic arst_n_o
);

  // Free-running clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Reset held low for the first cycles
  initial begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

// File: src/obi_axi_subsys_top.sv
// Two OBI core ports onto one AXI4-Lite master with at most one master transaction outstanding
`timescale 1ns/1ps

module obi_axi_subsys_top
  import obi_pkg::*;
  import axi_lite_pkg::*;
#(
  parameter int ADDR_W = OBI_ADDR_W,
  parameter int DATA_W = OBI_DATA_W
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // OBI instruction port
  input  logic                instr_req_i,
  input  logic [ADDR_W-1:0]   instr_addr_i,
  output logic                instr_gnt_o,
  output logic                instr_rvalid_o,
  output logic [DATA_W-1:0]   instr_rdata_o,
  output logic                instr_err_o,
  // OBI data port
  input  logic                data_req_i,
  input  logic                data_we_i,
  input  logic [DATA_W/8-1:0] data_be_i,
  input  logic [ADDR_W-1:0]   data_addr_i,
  input  logic [DATA_W-1:0]   data_wdata_i,
  output logic                data_gnt_o,
  output logic                data_rvalid_o,
  output logic [DATA_W-1:0]   data_rdata_o,
  output logic                data_err_o,
  // AXI4-Lite master
  output logic                m_awvalid_o,
  input  logic                m_awready_i,
  output logic [ADDR_W-1:0]   m_awaddr_o,
  output logic                m_wvalid_o,
  input  logic                m_wready_i,
  output logic [DATA_W-1:0]   m_wdata_o,
  output logic [DATA_W/8-1:0] m_wstrb_o,
  input  logic                m_bvalid_i,
  output logic                m_bready_o,
  input  logic [1:0]          m_bresp_i,
  output logic                m_arvalid_o,
  input  logic                m_arready_i,
  output logic [ADDR_W-1:0]   m_araddr_o,
  input  logic                m_rvalid_i,
  output logic                m_rready_o,
  input  logic [DATA_W-1:0]   m_rdata_i,
  input  logic [1:0]          m_rresp_i
);

  localparam int BE_W = OBI_BE_W * DATA_W / OBI_DATA_W;

  // ----------------------------------------
  // Bridge to arbiter channels
  // ----------------------------------------

  // Instruction side
  logic              i_ar_valid, i_ar_ready, i_r_valid;
  logic [ADDR_W-1:0] i_ar_addr;
  logic [DATA_W-1:0] i_r_data;
  axi_resp_e         i_r_resp;
  // Data side
  logic              d_ar_valid, d_ar_ready, d_r_valid;
  logic [ADDR_W-1:0] d_ar_addr;
  logic [DATA_W-1:0] d_r_data;
  axi_resp_e         d_r_resp;
  logic              d_aw_valid, d_aw_ready, d_b_valid;
  logic [ADDR_W-1:0] d_aw_addr;
  logic [DATA_W-1:0] d_w_data;
  logic [BE_W-1:0]   d_w_strb;
  axi_resp_e         d_b_resp;

  obi_instr_bridge #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) u_instr_bridge (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .req_i      (instr_req_i),
    .addr_i     (instr_addr_i),
    .gnt_o      (instr_gnt_o),
    .rvalid_o   (instr_rvalid_o),
    .rdata_o    (instr_rdata_o),
    .err_o      (instr_err_o),
    .ar_valid_o (i_ar_valid),
    .ar_addr_o  (i_ar_addr),
    .ar_ready_i (i_ar_ready),
    .r_valid_i  (i_r_valid),
    .r_data_i   (i_r_data),
    .r_resp_i   (i_r_resp)
  );

  obi_data_bridge #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) u_data_bridge (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .req_i      (data_req_i),
    .we_i       (data_we_i),
    .be_i       (data_be_i),
    .addr_i     (data_addr_i),
    .wdata_i    (data_wdata_i),
    .gnt_o      (data_gnt_o),
    .rvalid_o   (data_rvalid_o),
    .rdata_o    (data_rdata_o),
    .err_o      (data_err_o),
    .ar_valid_o (d_ar_valid),
    .ar_addr_o  (d_ar_addr),
    .ar_ready_i (d_ar_ready),
    .r_valid_i  (d_r_valid),
    .r_data_i   (d_r_data),
    .r_resp_i   (d_r_resp),
    .aw_valid_o (d_aw_valid),
    .aw_addr_o  (d_aw_addr),
    .w_data_o   (d_w_data),
    .w_strb_o   (d_w_strb),
    .aw_ready_i (d_aw_ready),
    .b_valid_i  (d_b_valid),
    .b_resp_i   (d_b_resp)
  );

  // Round-robin merge onto the master port
  axi_lite_arbiter #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) u_arbiter (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .i_ar_valid_i (i_ar_valid),
    .i_ar_addr_i  (i_ar_addr),
    .i_ar_ready_o (i_ar_ready),
    .i_r_valid_o  (i_r_valid),
    .i_r_data_o   (i_r_data),
    .i_r_resp_o   (i_r_resp),
    .d_ar_valid_i (d_ar_valid),
    .d_ar_addr_i  (d_ar_addr),
    .d_aw_valid_i (d_aw_valid),
    .d_aw_addr_i  (d_aw_addr),
    .d_w_data_i   (d_w_data),
    .d_w_strb_i   (d_w_strb),
    .d_ar_ready_o (d_ar_ready),
    .d_aw_ready_o (d_aw_ready),
    .d_r_valid_o  (d_r_valid),
    .d_r_data_o   (d_r_data),
    .d_r_resp_o   (d_r_resp),
    .d_b_valid_o  (d_b_valid),
    .d_b_resp_o   (d_b_resp),
    .m_awvalid_o  (m_awvalid_o),
    .m_awready_i  (m_awready_i),
    .m_awaddr_o   (m_awaddr_o),
    .m_wvalid_o   (m_wvalid_o),
    .m_wready_i   (m_wready_i),
    .m_wdata_o    (m_wdata_o),
    .m_wstrb_o    (m_wstrb_o),
    .m_bvalid_i   (m_bvalid_i),
    .m_bready_o   (m_bready_o),
    .m_bresp_i    (m_bresp_i),
    .m_arvalid_o  (m_arvalid_o),
    .m_arready_i  (m_arready_i),
    .m_araddr_o   (m_araddr_o),
    .m_rvalid_i   (m_rvalid_i),
    .m_rready_o   (m_rready_o),
    .m_rdata_i    (m_rdata_i),
    .m_rresp_i    (m_rresp_i)
  );

endmodule

// File: src/axi_lite_arbiter.sv
// Two requesters share one AXI4-Lite master with a single outstanding transaction at a time
`timescale 1ns/1ps

module axi_lite_arbiter
  import obi_pkg::*;
  import axi_lite_pkg::*;
#(
  parameter int ADDR_W = OBI_ADDR_W,
  parameter int DATA_W = OBI_DATA_W
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // Instruction bridge
  input  logic                i_ar_valid_i,
  input  logic [ADDR_W-1:0]   i_ar_addr_i,
  output logic                i_ar_ready_o,
  output logic                i_r_valid_o,
  output logic [DATA_W-1:0]   i_r_data_o,
  output axi_resp_e           i_r_resp_o,
  // Data bridge
  input  logic                d_ar_valid_i,
  input  logic [ADDR_W-1:0]   d_ar_addr_i,
  input  logic                d_aw_valid_i,
  input  logic [ADDR_W-1:0]   d_aw_addr_i,
  input  logic [DATA_W-1:0]   d_w_data_i,
  input  logic [DATA_W/8-1:0] d_w_strb_i,
  output logic                d_ar_ready_o,
  output logic                d_aw_ready_o,
  output logic                d_r_valid_o,
  output logic [DATA_W-1:0]   d_r_data_o,
  output axi_resp_e           d_r_resp_o,
  output logic                d_b_valid_o,
  output axi_resp_e           d_b_resp_o,
  // AXI4-Lite master
  output logic                m_awvalid_o,
  input  logic                m_awready_i,
  output logic [ADDR_W-1:0]   m_awaddr_o,
  output logic                m_wvalid_o,
  input  logic                m_wready_i,
  output logic [DATA_W-1:0]   m_wdata_o,
  output logic [DATA_W/8-1:0] m_wstrb_o,
  input  logic                m_bvalid_i,
  output logic                m_bready_o,
  input  logic [1:0]          m_bresp_i,
  output logic                m_arvalid_o,
  input  logic                m_arready_i,
  output logic [ADDR_W-1:0]   m_araddr_o,
  input  logic                m_rvalid_i,
  output logic                m_rready_o,
  input  logic [DATA_W-1:0]   m_rdata_i,
  input  logic [1:0]          m_rresp_i
);

  localparam int STRB_W = DATA_W / 8;

  arb_state_e        state_q, state_d;
  arb_port_e         last_q, win;
  logic              d_req;
  logic              grant;
  logic              wr_q;
  logic              aw_done_q, w_done_q;
  logic              aw_ok, w_ok;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q;
  logic [STRB_W-1:0] strb_q;

  // ----------------------------------------
  // Round-robin grant
  // ----------------------------------------

  assign d_req = d_ar_valid_i | d_aw_valid_i;
  assign grant = (state_q == ARB_IDLE) & (i_ar_valid_i | d_req);

  // On a tie the port that did not own the last grant wins
  always_comb begin
    if (i_ar_valid_i && d_req) win = (last_q == PORT_INSTR) ? PORT_DATA : PORT_INSTR;
    else if (d_req) win = PORT_DATA;
    else win = PORT_INSTR;
  end

  assign i_ar_ready_o = grant & (win == PORT_INSTR);
  // Write wins if the data bridge ever showed both
  assign d_aw_ready_o = grant & (win == PORT_DATA) & d_aw_valid_i;
  assign d_ar_ready_o = grant & (win == PORT_DATA) & d_ar_valid_i & ~d_aw_valid_i;

  // ----------------------------------------
  // Master bus
  // ----------------------------------------

  assign m_araddr_o  = addr_q;
  assign m_awaddr_o  = addr_q;
  assign m_wdata_o   = wdata_q;
  assign m_wstrb_o   = strb_q;
  assign m_arvalid_o = (state_q == ARB_RD);
  // AW and W rise together and drop on their own handshakes
  assign m_awvalid_o = (state_q == ARB_WR) & ~aw_done_q;
  assign m_wvalid_o  = (state_q == ARB_WR) & ~w_done_q;
  assign aw_ok       = aw_done_q | m_awready_i;
  assign w_ok        = w_done_q | m_wready_i;
  assign m_rready_o  = (state_q == ARB_RESP) & ~wr_q;
  assign m_bready_o  = (state_q == ARB_RESP) & wr_q;

  // Responses steered to the owner in the master handshake cycle
  assign i_r_valid_o = m_rready_o & m_rvalid_i & (last_q == PORT_INSTR);
  assign d_r_valid_o = m_rready_o & m_rvalid_i & (last_q == PORT_DATA);
  // Only the data port writes
  assign d_b_valid_o = m_bready_o & m_bvalid_i;
  assign i_r_data_o  = m_rdata_i;
  assign d_r_data_o  = m_rdata_i;
  assign i_r_resp_o  = axi_resp_e'(m_rresp_i);
  assign d_r_resp_o  = axi_resp_e'(m_rresp_i);
  assign d_b_resp_o  = axi_resp_e'(m_bresp_i);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ARB_IDLE: begin
        if (grant) state_d = (d_aw_ready_o) ? ARB_WR : ARB_RD;
      end
      ARB_RD:   if (m_arready_i) state_d = ARB_RESP;
      // Write phase ends once both AW and W are through
      ARB_WR:   if (aw_ok && w_ok) state_d = ARB_RESP;
      default:  if (wr_q ? m_bvalid_i : m_rvalid_i) state_d = ARB_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= ARB_IDLE;
      // Instruction port first after reset
      last_q    <= PORT_DATA;
      wr_q      <= 1'b0;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (grant) begin
        last_q <= win;
        wr_q   <= d_aw_ready_o;
      end
      // Completion flags live only inside the write phase
      aw_done_q <= (state_q == ARB_WR) & aw_ok;
      w_done_q  <= (state_q == ARB_WR) & w_ok;
    end
  end

  // Request payload of the granted port
  always_ff @(posedge clk_i) begin
    if (grant) begin
      if (win == PORT_INSTR) addr_q <= i_ar_addr_i;
      else if (d_aw_valid_i) addr_q <= d_aw_addr_i;
      else addr_q <= d_ar_addr_i;
      wdata_q <= d_w_data_i;
      strb_q  <= d_w_strb_i;
    end
  end

endmodule

// File: src/obi_data_bridge.sv
// Read/write OBI port with one request at a time and write responses returning zero read data
`timescale 1ns/1ps

module obi_data_bridge
  import obi_pkg::*;
  import axi_lite_pkg::*;
#(
  parameter int ADDR_W = OBI_ADDR_W,
  parameter int DATA_W = OBI_DATA_W
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // OBI data port from the core
  input  logic                req_i,
  input  logic                we_i,
  input  logic [DATA_W/8-1:0] be_i,
  input  logic [ADDR_W-1:0]   addr_i,
  input  logic [DATA_W-1:0]   wdata_i,
  output logic                gnt_o,
  output logic                rvalid_o,
  output logic [DATA_W-1:0]   rdata_o,
  output logic                err_o,
  // Read channels toward the arbiter
  output logic                ar_valid_o,
  output logic [ADDR_W-1:0]   ar_addr_o,
  input  logic                ar_ready_i,
  input  logic                r_valid_i,
  input  logic [DATA_W-1:0]   r_data_i,
  input  axi_resp_e           r_resp_i,
  // Write channels toward the arbiter
  output logic                aw_valid_o,
  output logic [ADDR_W-1:0]   aw_addr_o,
  output logic [DATA_W-1:0]   w_data_o,
  output logic [DATA_W/8-1:0] w_strb_o,
  input  logic                aw_ready_i,
  input  logic                b_valid_i,
  input  axi_resp_e           b_resp_i
);

  // Byte enables scale with the data width
  localparam int BE_W = OBI_BE_W * DATA_W / OBI_DATA_W;

  bridge_state_e     state_q, state_d;
  logic              we_q;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q;
  logic [BE_W-1:0]   be_q;
  logic [DATA_W-1:0] rdata_q;
  logic              err_q;
  logic              req_take;
  logic              rsp_take;

  assign gnt_o      = req_i & (state_q == BR_IDLE);

  // ----------------------------------------
  // Request side
  // ----------------------------------------

  // Direction picks exactly one request channel
  assign ar_valid_o = (state_q == BR_ADDR) & ~we_q;
  assign aw_valid_o = (state_q == BR_ADDR) & we_q;
  // Same captured address on both channels
  assign ar_addr_o  = addr_q;
  assign aw_addr_o  = addr_q;
  assign w_data_o   = wdata_q;
  assign w_strb_o   = be_q;
  // Single ready covers AW and W together
  assign req_take   = we_q ? aw_ready_i : ar_ready_i;

  // ----------------------------------------
  // Response side
  // ----------------------------------------

  // B for writes and R for reads
  assign rsp_take   = (state_q == BR_RESP) & (we_q ? b_valid_i : r_valid_i);
  assign rvalid_o   = (state_q == BR_DONE);
  assign rdata_o    = rdata_q;
  assign err_o      = err_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      BR_IDLE: if (gnt_o) state_d = BR_ADDR;
      BR_ADDR: if (req_take) state_d = BR_RESP;
      BR_RESP: if (rsp_take) state_d = BR_DONE;
      default: state_d = BR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= BR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Whole OBI request captured on acceptance
  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      we_q    <= we_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
      be_q    <= be_i;
    end
    if (rsp_take) begin
      // Writes return zero data
      rdata_q <= we_q ? '0 : r_data_i;
      err_q   <= resp_is_err(we_q ? b_resp_i : r_resp_i);
    end
  end

endmodule

// File: src/obi_instr_bridge.sv
// Read-only OBI port with one request at a time and the R response always taken without a ready
`timescale 1ns/1ps

module obi_instr_bridge
  import obi_pkg::*;
  import axi_lite_pkg::*;
#(
  parameter int ADDR_W = OBI_ADDR_W,
  parameter int DATA_W = OBI_DATA_W
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  // OBI instruction port from the core
  input  logic              req_i,
  input  logic [ADDR_W-1:0] addr_i,
  output logic              gnt_o,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o,
  output logic              err_o,
  // Read request toward the arbiter
  output logic              ar_valid_o,
  output logic [ADDR_W-1:0] ar_addr_o,
  input  logic              ar_ready_i,
  // Read response from the arbiter
  input  logic              r_valid_i,
  input  logic [DATA_W-1:0] r_data_i,
  input  axi_resp_e         r_resp_i
);

  bridge_state_e     state_q, state_d;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] rdata_q;
  logic              err_q;
  logic              r_take;

  // Core stalls on gnt while a fetch is in flight
  assign gnt_o      = req_i & (state_q == BR_IDLE);
  // Request valid starts the cycle after acceptance
  assign ar_valid_o = (state_q == BR_ADDR);
  assign ar_addr_o  = addr_q;
  // Response handshake with the arbiter
  assign r_take     = (state_q == BR_RESP) & r_valid_i;
  // Registered response toward the core
  assign rvalid_o   = (state_q == BR_DONE);
  assign rdata_o    = rdata_q;
  assign err_o      = err_q;

  // ----------------------------------------
  // FSM
  // ----------------------------------------

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      BR_IDLE: if (gnt_o) state_d = BR_ADDR;
      BR_ADDR: if (ar_ready_i) state_d = BR_RESP;
      BR_RESP: if (r_take) state_d = BR_DONE;
      // Single rvalid pulse then free again
      default: state_d = BR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= BR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Address on acceptance and read result on the R handshake
  always_ff @(posedge clk_i) begin
    if (gnt_o) addr_q <= addr_i;
    if (r_take) begin
      rdata_q <= r_data_i;
      err_q   <= resp_is_err(r_resp_i);
    end
  end

endmodule

// File: common/axi_lite_pkg.sv
// AXI4-Lite encodings for a master with a single outstanding transaction and two requesters
package axi_lite_pkg;

  // ----------------------------------------
  // Response codes
  // ----------------------------------------

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  // SLVERR and DECERR both map to an OBI error
  function automatic logic resp_is_err(axi_resp_e resp);
    return (resp == RESP_SLVERR) || (resp == RESP_DECERR);
  endfunction

  // ----------------------------------------
  // Arbiter encodings
  // ----------------------------------------

  typedef enum logic [1:0] {
    // Looking for a requester
    ARB_IDLE = 2'd0,
    // Read address on the master bus
    ARB_RD   = 2'd1,
    // Write address and data on the master bus
    ARB_WR   = 2'd2,
    // Master ready high until the response arrives
    ARB_RESP = 2'd3
  } arb_state_e;

  // Owner of the current or last master transaction
  typedef enum logic {
    PORT_INSTR = 1'b0,
    PORT_DATA  = 1'b1
  } arb_port_e;

endpackage

// File: common/obi_pkg.sv
// Default OBI widths assume a 32-bit core bus with 8-bit byte lanes and one request in flight
package obi_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------

  // Core address bus
  parameter int OBI_ADDR_W = 32;
  // Core data bus
  parameter int OBI_DATA_W = 32;
  // One enable per byte lane of the data bus
  parameter int OBI_BE_W   = OBI_DATA_W / 8;

  // ----------------------------------------
  // Bridge FSM
  // ----------------------------------------

  // Shared by the instruction and data bridges
  typedef enum logic [1:0] {
    // Free for a new core request
    BR_IDLE = 2'd0,
    // AXI request valid until the arbiter takes it
    BR_ADDR = 2'd1,
    // Waiting for the R or B response
    BR_RESP = 2'd2,
    // One cycle of rvalid toward the core
    BR_DONE = 2'd3
  } bridge_state_e;

endpackage
